//--- Makefile
# Verilator build and run for the float ALU testbench

VERILATOR ?= verilator
TOP ?= float_alu_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
# keep running after an assertion error so the testbench prints its status
SIM_FLAGS ?= +verilator+error+limit+100

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(SIM_BIN) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi; \
	if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
src/float_pkg.sv
src/float_multiplier.sv
src/float_adder.sv
src/float_alu.sv
tests/float_alu_assert.sv
tests/float_alu_tb.sv

//--- src/float_adder.sv
`timescale 1ns/10ps

module float_adder (
	input logic in_clk, in_rst,

	// one-cycle start strobe
	input logic in_start,

	// subtract b instead of adding, sampled on start
	input logic in_sub,

	// operand pair, sampled on start
	input float_pkg::float_operands_t in_ops,

	// sum, valid while finished
	output float_pkg::float_t out_sum,

	// high in the Finished state
	output logic out_finished
);

	import float_pkg::*;

	// adder states
	typedef enum logic [2 : 0] {
		Idle,     // after reset
		Load,     // pick larger operand, exponent difference
		Align,    // barrel shift of the smaller mantissa
		Add,      // mantissa sum or difference
		Norm,     // one bit per cycle until hidden bit set
		Finished  // result valid
	} state_t;

	state_t state, state_next;

	// registered inputs
	float_operands_t ops_q, ops_next;
	logic sub_q, sub_next;

	// working values
	logic sign_q, sign_next;     // result sign, taken from the larger operand
	logic diff_q, diff_next;     // signs differ, so subtract magnitudes
	exp_t exp_q, exp_next;       // larger exponent, then result exponent
	exp_t shift_q, shift_next;   // exponent difference
	mant_t big_q, big_next;      // larger magnitude
	mant_t small_q, small_next;  // smaller magnitude, aligned in Align
	wide_mant_t sum_q, sum_next;

	float_fields_t a_f, b_f, res_f;
	mant_t a_mant, b_mant;
	logic b_sign;      // b sign after optional negation
	logic a_larger;    // |a| >= |b|
	wide_mant_t sum_c; // combinational sum for the Add state

	assign a_f = float_fields_t'(ops_q.a);
	assign b_f = float_fields_t'(ops_q.b);
	assign a_mant = {1'b1, a_f.frac};
	assign b_mant = {1'b1, b_f.frac};
	assign b_sign = b_f.sign ^ sub_q; // a - b == a + (-b)

	// magnitude compare, exponent first then fraction
	assign a_larger = {a_f.exp, a_f.frac} >= {b_f.exp, b_f.frac};

	// big >= small after alignment, so the difference never wraps
	assign sum_c = diff_q ? wide_mant_t'(big_q) - wide_mant_t'(small_q)
		: wide_mant_t'(big_q) + wide_mant_t'(small_q);

	assign res_f.sign = sign_q;
	assign res_f.exp = exp_q;
	assign res_f.frac = sum_q[FRAC_BITS-1 : 0];

	assign out_sum = float_t'(res_f);
	assign out_finished = (state == Finished);

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			state <= Idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge in_clk) begin
		ops_q <= ops_next;
		sub_q <= sub_next;
		sign_q <= sign_next;
		diff_q <= diff_next;
		exp_q <= exp_next;
		shift_q <= shift_next;
		big_q <= big_next;
		small_q <= small_next;
		sum_q <= sum_next;
	end

	always_comb begin
		state_next = state;
		ops_next = ops_q;
		sub_next = sub_q;
		sign_next = sign_q;
		diff_next = diff_q;
		exp_next = exp_q;
		shift_next = shift_q;
		big_next = big_q;
		small_next = small_q;
		sum_next = sum_q;

		case (state)
			Idle, Finished: begin
				if (in_start) begin
					ops_next = in_ops;
					sub_next = in_sub;
					state_next = Load;
				end
			end

			Load: begin
				diff_next = a_f.sign ^ b_sign;
				if (a_larger) begin
					sign_next = a_f.sign;
					exp_next = a_f.exp;
					shift_next = a_f.exp - b_f.exp;
					big_next = a_mant;
					small_next = b_mant;
				end else begin
					sign_next = b_sign;
					exp_next = b_f.exp;
					shift_next = b_f.exp - a_f.exp;
					big_next = b_mant;
					small_next = a_mant;
				end
				state_next = Align;
			end

			Align: begin
				small_next = small_q >> shift_q; // shifted-out bits dropped
				state_next = Add;
			end

			Add: begin
				if (sum_c == '0) begin
					// exact cancellation, encode as +0
					sign_next = 1'b0;
					exp_next = '0;
					sum_next = '0;
					state_next = Finished;
				end else begin
					sum_next = sum_c;
					state_next = Norm;
				end
			end

			Norm: begin
				if (sum_q[FRAC_BITS+1]) begin
					sum_next = sum_q >> 1; // carry out, at most once
					exp_next = exp_q + 1'b1;
				end else if (!sum_q[FRAC_BITS]) begin
					sum_next = sum_q << 1;
					exp_next = exp_q - 1'b1;
				end else begin
					state_next = Finished;
				end
			end

			default: state_next = Idle;
		endcase
	end

endmodule

//--- src/float_alu.sv
`timescale 1ns/10ps

module float_alu (
	input logic in_clk, in_rst,

	// start pulse, dropped while busy
	input logic in_start,
	input float_pkg::op_t in_op,
	input float_pkg::float_operands_t in_ops,

	output float_pkg::float_t out_result,
	output logic out_busy,
	output logic out_finished
);

	import float_pkg::*;

	// latched request
	float_operands_t ops_q;
	op_t op_q;

	logic dispatch_q;  // one-cycle start into the selected unit
	logic sel_add_q;   // unit of the last accepted start
	logic busy_q, finished_q;
	float_t result_q;

	logic accept;      // start seen while idle
	logic in_is_add;   // decoded from in_op
	logic unit_fin, unit_done;
	float_t unit_res;

	logic mul_start, mul_fin;
	logic add_start, add_sub, add_fin;
	float_t mul_prod, add_sum;

	assign accept = in_start & ~busy_q;

	always_comb begin
		case (in_op)
			OP_MUL: in_is_add = 1'b0;
			OP_ADD, OP_SUB: in_is_add = 1'b1;
			default: in_is_add = 1'b0; // code 3 runs as multiply
		endcase
	end

	assign mul_start = dispatch_q & ~sel_add_q;
	assign add_start = dispatch_q & sel_add_q;
	assign add_sub = (op_q == OP_SUB);

	// unit finished is still high from its last run during the dispatch cycle
	assign unit_fin = sel_add_q ? add_fin : mul_fin;
	assign unit_res = sel_add_q ? add_sum : mul_prod;
	assign unit_done = busy_q & ~dispatch_q & unit_fin;

	assign out_result = result_q;
	assign out_busy = busy_q;
	assign out_finished = finished_q;

	always_ff @(posedge in_clk) begin
		if (accept) begin
			ops_q <= in_ops;
			op_q <= in_op;
		end
	end

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			dispatch_q <= 1'b0;
			sel_add_q <= 1'b0;
			busy_q <= 1'b0;
			finished_q <= 1'b0;
			result_q <= '0; // zero until the first result
		end else begin
			dispatch_q <= accept;
			if (accept) begin
				sel_add_q <= in_is_add;
				busy_q <= 1'b1;
				finished_q <= 1'b0;
			end else if (unit_done) begin
				busy_q <= 1'b0;
				finished_q <= 1'b1;
				result_q <= unit_res; // held until next accept
			end
		end
	end

	float_multiplier i_mul (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_start(mul_start),
		.in_ops(ops_q),
		.out_prod(mul_prod),
		.out_finished(mul_fin)
	);

	float_adder i_add (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_start(add_start),
		.in_sub(add_sub),
		.in_ops(ops_q),
		.out_sum(add_sum),
		.out_finished(add_fin)
	);

endmodule

//--- src/float_multiplier.sv
`timescale 1ns/10ps

module float_multiplier (
	input logic in_clk, in_rst,

	// one-cycle start strobe
	input logic in_start,

	// operand pair, sampled on start
	input float_pkg::float_operands_t in_ops,

	// product, valid while finished
	output float_pkg::float_t out_prod,

	// high in the Finished state
	output logic out_finished
);

	import float_pkg::*;

	// multiplier states
	typedef enum logic [2 : 0] {
		Idle,       // after reset, nothing computed yet
		Reset,      // clear working registers
		Mult,       // exponent sum and mantissa product
		Norm_Over,  // shift right while mantissa >= 2
		Norm_Under, // shift left while hidden bit clear
		Finished    // result valid, wait for next start
	} state_t;

	state_t state, state_next;

	// registered operands and working values
	float_operands_t ops_q, ops_next;
	logic sign_q, sign_next;
	exp_t exp_q, exp_next;
	wide_mant_t mant_q, mant_next;

	// operand fields
	float_fields_t a_f, b_f;
	mant_t a_mant, b_mant;

	// result fields
	float_fields_t res_f;

	logic in_sign;     // sign of the incoming operands
	logic mant_over;   // mantissa at or above 2.0
	logic hidden_bit;  // leading one position
	logic frac_nz;     // any stored fraction bit set

	assign a_f = float_fields_t'(ops_q.a);
	assign b_f = float_fields_t'(ops_q.b);
	assign a_mant = {1'b1, a_f.frac}; // add hidden one
	assign b_mant = {1'b1, b_f.frac};

	assign in_sign = in_ops.a[FLOAT_BITS-1] ^ in_ops.b[FLOAT_BITS-1];

	assign mant_over = (mant_q >> (FRAC_BITS + 1)) != '0;
	assign hidden_bit = mant_q[FRAC_BITS];
	assign frac_nz = mant_q[FRAC_BITS-1 : 0] != '0;

	// product word, hidden bit dropped
	assign res_f.sign = sign_q;
	assign res_f.exp = exp_q;
	assign res_f.frac = mant_q[FRAC_BITS-1 : 0];

	assign out_prod = float_t'(res_f);
	assign out_finished = (state == Finished);

	// state register
	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			state <= Idle;
		end else begin
			state <= state_next;
		end
	end

	// working registers, only meaningful after a start
	always_ff @(posedge in_clk) begin
		ops_q <= ops_next;
		sign_q <= sign_next;
		exp_q <= exp_next;
		mant_q <= mant_next;
	end

	// next state and datapath
	always_comb begin
		state_next = state; // hold by default
		ops_next = ops_q;
		sign_next = sign_q;
		exp_next = exp_q;
		mant_next = mant_q;

		case (state)
			Idle, Finished: begin
				// latch operands so inputs may move during the calculation
				if (in_start) begin
					ops_next = in_ops;
					sign_next = in_sign;
					state_next = Reset;
				end
			end

			Reset: begin
				exp_next = '0;
				mant_next = '0;
				state_next = Mult;
			end

			Mult: begin
				// biased sum, bias removed once
				exp_next = exp_t'(int'(a_f.exp) + int'(b_f.exp) - EXP_BIAS);
				// 48-bit product back to 23 fraction bits, truncated
				mant_next = (wide_mant_t'(a_mant) * wide_mant_t'(b_mant)) >> FRAC_BITS;
				state_next = Norm_Over;
			end

			Norm_Over: begin
				if (mant_over) begin
					mant_next = mant_q >> 1; // lsb lost
					exp_next = exp_q + 1'b1;
				end else begin
					state_next = Norm_Under;
				end
			end

			Norm_Under: begin
				if (frac_nz && !hidden_bit) begin
					mant_next = mant_q << 1;
					exp_next = exp_q - 1'b1;
				end else begin
					state_next = Finished;
				end
			end

			default: state_next = Idle;
		endcase
	end

endmodule

//--- src/float_pkg.sv
package float_pkg;

	// single precision layout
	localparam int FLOAT_BITS = 32; // whole word
	localparam int EXP_BITS = 8;    // biased exponent field
	localparam int FRAC_BITS = 23;  // stored fraction, hidden one not stored
	localparam int EXP_BIAS = 127;

	// plain vector types
	typedef logic [FLOAT_BITS-1 : 0] float_t;      // packed float word
	typedef logic [EXP_BITS-1 : 0] exp_t;          // biased exponent
	typedef logic [FRAC_BITS-1 : 0] frac_t;        // fraction bits only
	typedef logic [FRAC_BITS : 0] mant_t;          // fraction with hidden one
	typedef logic [2*FRAC_BITS+1 : 0] wide_mant_t; // product or sum with headroom

	// field view of a float word, same bit order as float_t
	typedef struct packed {
		logic sign;
		exp_t exp;
		frac_t frac;
	} float_fields_t;

	// operand pair, a in the upper half
	typedef struct packed {
		float_t a;
		float_t b;
	} float_operands_t;

	// operation select
	typedef logic [1 : 0] op_t;

	localparam op_t OP_MUL = 2'd0;
	localparam op_t OP_ADD = 2'd1;
	localparam op_t OP_SUB = 2'd2; // a - b
	// code 3 is unused and decoded as multiply

endpackage

//--- tests/float_alu_assert.sv
`timescale 1ns/10ps

module float_alu_assert (
	input logic in_clk, in_rst,
	input logic in_start,
	input logic out_busy, out_finished,
	input float_pkg::float_t out_result
);

	// failure counts, one per property
	int excl_fails = 0;
	int busy_fails = 0;
	int hold_fails = 0;

	excl_chk: assert property (@(posedge in_clk) disable iff (in_rst)
		!(out_finished && out_busy))
		else begin
			excl_fails++;
			$error("out_finished and out_busy high in the same cycle");
		end

	// accepted start shows up as busy one cycle later
	busy_chk: assert property (@(posedge in_clk) disable iff (in_rst)
		(in_start && !out_busy) |=> out_busy)
		else begin
			busy_fails++;
			$error("accepted start did not raise out_busy");
		end

	hold_chk: assert property (@(posedge in_clk) disable iff (in_rst)
		(out_finished && $past(out_finished)) |-> $stable(out_result))
		else begin
			hold_fails++;
			$error("out_result changed while out_finished stayed high");
		end

endmodule

bind float_alu float_alu_assert i_float_alu_assert (
	.in_clk(in_clk), .in_rst(in_rst),
	.in_start(in_start),
	.out_busy(out_busy), .out_finished(out_finished),
	.out_result(out_result)
);

//--- tests/float_alu_tb.sv
`timescale 1ns/10ps

module float_alu_tb;

	import float_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_MUL = 300;
	localparam int NUM_ADD = 300;
	localparam int NUM_OP3 = 10;
	localparam int NUM_OPS = NUM_MUL + NUM_ADD + NUM_OP3 + 2; // two directed cancels
	localparam int OP_CYCLES = 40; // per operation budget
	localparam int TIMEOUT_NS = NUM_OPS * OP_CYCLES * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

	logic in_clk, in_rst, in_start;
	op_t in_op;
	float_operands_t in_ops;
	float_t out_result;
	logic out_busy, out_finished;

	integer seed = 84419;
	int value_errors = 0;
	int level_errors = 0;
	int timeout_errors = 0;
	int assert_errors;
	float_t last_expected; // model result of the last operation

	float_alu i_float_alu (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_start(in_start), .in_op(in_op), .in_ops(in_ops),
		.out_result(out_result), .out_busy(out_busy), .out_finished(out_finished)
	);

	initial begin
		in_clk = 1'b0;
		forever #(CLK_PERIOD / 2) in_clk = ~in_clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the test sequence never completed", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_float(input float_t got, input float_t expv, input string what);
		if (got !== expv) begin
			value_errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, expv);
		end
	endtask

	task automatic check_level(input logic got, input logic expv, input string what);
		if (got !== expv) begin
			level_errors++;
			$display("FAILED %0t: %s got %b expected %b", $time, what, got, expv);
		end
	endtask

	// normal operand, exponent 100..154 keeps results in range
	function automatic float_t rand_float();
		float_fields_t f;
		logic [31:0] r;
		r = $random(seed);
		f.sign = r[0];
		r = $random(seed);
		f.exp = exp_t'(32'd100 + r % 32'd55);
		r = $random(seed);
		f.frac = r[FRAC_BITS-1 : 0];
		return float_t'(f);
	endfunction

	// truncating multiply, integer mantissas with 23 fraction bits
	task automatic model_mul(input float_t a, input float_t b, output float_t r);
		float_fields_t fa, fb, fr;
		logic [63:0] m;
		int e;
		fa = float_fields_t'(a);
		fb = float_fields_t'(b);
		m = (64'({1'b1, fa.frac}) * 64'({1'b1, fb.frac})) >> FRAC_BITS;
		e = int'(fa.exp) + int'(fb.exp) - EXP_BIAS;
		while (m >= (64'd1 << (FRAC_BITS + 1))) begin
			m = m >> 1; // product at or above 2.0
			e++;
		end
		fr.sign = fa.sign ^ fb.sign;
		fr.exp = exp_t'(e);
		fr.frac = m[FRAC_BITS-1 : 0];
		r = float_t'(fr);
	endtask

	task automatic model_add(input float_t a, input float_t b, input logic sub,
			output float_t r);
		float_fields_t fa, fb, fr;
		logic sb, sgn;
		logic [63:0] big_m, small_m, s;
		int e, sh;
		fa = float_fields_t'(a);
		fb = float_fields_t'(b);
		sb = fb.sign ^ sub; // negate b for subtract
		if ({fa.exp, fa.frac} >= {fb.exp, fb.frac}) begin
			sgn = fa.sign;
			e = int'(fa.exp);
			sh = int'(fa.exp) - int'(fb.exp);
			big_m = 64'({1'b1, fa.frac});
			small_m = 64'({1'b1, fb.frac});
		end else begin
			sgn = sb;
			e = int'(fb.exp);
			sh = int'(fb.exp) - int'(fa.exp);
			big_m = 64'({1'b1, fb.frac});
			small_m = 64'({1'b1, fa.frac});
		end
		small_m = small_m >> sh; // alignment drops low bits
		s = (fa.sign != sb) ? big_m - small_m : big_m + small_m;
		if (s == 64'd0) begin
			r = '0; // exact zero as all zeros
		end else begin
			while (s >= (64'd1 << (FRAC_BITS + 1))) begin
				s = s >> 1;
				e++;
			end
			while (s < (64'd1 << FRAC_BITS)) begin
				s = s << 1;
				e--;
			end
			fr.sign = sgn;
			fr.exp = exp_t'(e);
			fr.frac = s[FRAC_BITS-1 : 0];
			r = float_t'(fr);
		end
	endtask

	// called at a falling edge, returns at the falling edge where finished is seen
	task automatic run_op(input op_t op, input float_t a, input float_t b, input bit disturb,
			output float_t res);
		int cycles;
		cycles = 0;
		in_start = 1'b1;
		in_op = op;
		in_ops.a = a;
		in_ops.b = b;
		@(negedge in_clk);
		in_start = 1'b0;
		check_level(out_busy, 1'b1, "busy after start");
		check_level(out_finished, 1'b0, "finished after start");
		while (!out_finished && cycles < OP_CYCLES) begin
			@(negedge in_clk);
			cycles++;
			in_start = 1'b0;
			if (disturb) begin
				in_op = op_t'($random(seed)); // inputs move mid calculation
				in_ops.a = rand_float();
				in_ops.b = rand_float();
				in_start = (cycles == 1) && out_busy; // start while busy, must be dropped
			end
		end
		if (!out_finished) begin
			timeout_errors++;
			$display("operation %0d on %h and %h did not finish within %0d cycles",
				op, a, b, OP_CYCLES);
		end
		res = out_result;
	endtask

	task automatic check_op(input op_t op, input float_t a, input float_t b, input bit disturb,
			input string what);
		float_t expv, got;
		if (op == OP_ADD) begin
			model_add(a, b, 1'b0, expv);
		end else if (op == OP_SUB) begin
			model_add(a, b, 1'b1, expv);
		end else begin
			model_mul(a, b, expv); // code 3 too
		end
		last_expected = expv;
		run_op(op, a, b, disturb, got);
		check_float(got, expv, what);
		check_level(out_busy, 1'b0, "busy at finish");
	endtask

	// no start, inputs toggling, result and finished must stay
	task automatic hold_check(input float_t held);
		repeat (3) begin
			@(negedge in_clk);
			in_op = op_t'($random(seed));
			in_ops.a = rand_float();
			in_ops.b = rand_float();
			check_float(out_result, held, "result held without start");
			check_level(out_finished, 1'b1, "finished held without start");
		end
	endtask

	initial begin
		float_t a, b;
		float_fields_t fa, fb;
		op_t op;
		logic [31:0] r;
		in_rst = 1'b1;
		in_start = 1'b0;
		in_op = OP_MUL;
		in_ops = '0;
		repeat (RESET_CYCLES) @(posedge in_clk);
		@(negedge in_clk);
		in_rst = 1'b0;
		@(negedge in_clk);
		check_level(out_busy, 1'b0, "busy after reset");
		check_level(out_finished, 1'b0, "finished after reset");
		check_float(out_result, '0, "result after reset");

		a = rand_float();
		check_op(OP_SUB, a, a, 1'b0, "a - a");
		check_float(out_result, '0, "a - a is zero");

		for (int i = 0; i < NUM_MUL; i++) begin
			check_op(OP_MUL, rand_float(), rand_float(), (i % 20) == 7,
				$sformatf("mul %0d", i));
			if (i % 50 == 11) hold_check(last_expected);
		end

		for (int i = 0; i < NUM_ADD; i++) begin
			a = rand_float();
			b = rand_float();
			fa = float_fields_t'(a);
			fb = float_fields_t'(b);
			if (i % 6 == 1) begin
				fb.exp = fa.exp; // equal exponents
				b = float_t'(fb);
			end else if (i % 6 == 3) begin
				b = {~a[FLOAT_BITS-1], a[FLOAT_BITS-2 : 0]}; // same magnitude, other sign
			end
			r = $random(seed);
			op = r[0] ? OP_SUB : OP_ADD;
			check_op(op, a, b, (i % 20) == 13, $sformatf("add/sub %0d", i));
			if (i % 50 == 29) hold_check(last_expected);
		end

		for (int i = 0; i < NUM_OP3; i++) begin
			check_op(2'd3, rand_float(), rand_float(), 1'b0, $sformatf("op3 %0d", i));
		end

		a = rand_float();
		check_op(OP_ADD, a, {~a[FLOAT_BITS-1], a[FLOAT_BITS-2 : 0]}, 1'b0, "a + -a");
		check_float(out_result, '0, "a + -a is zero");

		assert_errors = i_float_alu.i_float_alu_assert.excl_fails
			+ i_float_alu.i_float_alu_assert.busy_fails
			+ i_float_alu.i_float_alu_assert.hold_fails;
		$display("errors: value %0d, level %0d, timeout %0d, assertion %0d",
			value_errors, level_errors, timeout_errors, assert_errors);
		if (value_errors + level_errors + timeout_errors + assert_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
